/* Bender.yml */
package:
  name: pixel_compositor

sources:
  - src/comp_pkg.sv
  - src/window_decode.sv
  - src/layer_sort.sv
  - src/palette_ram.sv
  - src/color_fetch.sv
  - src/pixel_compositor.sv
  - target: test
    files:
      - sim/tb_pixel_compositor.sv

/* pixel_compositor.f */
src/comp_pkg.sv
src/window_decode.sv
src/layer_sort.sv
src/palette_ram.sv
src/color_fetch.sv
src/pixel_compositor.sv
sim/tb_pixel_compositor.sv

/* sim/tb_pixel_compositor.sv */
module tb_pixel_compositor;
    import comp_pkg::*;

    localparam int drain_limit = 64;

    logic               clk;
    logic               rst_n;
    win_cfg_t           cfg;
    logic               pix_valid;
    pixel_in_t          pix;
    logic               pal_we;
    logic [pal_aw-1:0]  pal_addr;
    logic [color_w-1:0] pal_data;
    logic               out_valid;
    pixel_out_t         out;

    logic [15:0]         lfsr = 16'd3;
    logic [color_w-1:0]  pal_model [2**pal_aw];
    pixel_out_t          exp_q [$];
    win_cfg_t            cur_cfg;
    logic [pipe_lat-1:0] valid_hist;
    int                  value_errs;
    int                  other_errs;

    pixel_compositor dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .pix_valid (pix_valid),
        .pix       (pix),
        .pal_we    (pal_we),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .out_valid (out_valid),
        .out       (out)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // galois lfsr stepped once for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic point_in_rect(input win_rect_t r, input logic [7:0] x,
                                           input logic [7:0] y);
        return x >= r.left && x < r.right && y >= r.top && y < r.bottom;
    endfunction

    function automatic logic [5:0] select_mask(input win_cfg_t c, input pixel_in_t p);
        if (!(c.win0_on || c.win1_on || c.objwin_on))
            return 6'h3f;
        if (c.win0_on && point_in_rect(c.win0_rect, p.x, p.y))
            return c.in0;
        if (c.win1_on && point_in_rect(c.win1_rect, p.x, p.y))
            return c.in1;
        if (c.objwin_on && p.obj.objwin)
            return c.inobj;
        return c.out;
    endfunction

    // reference model for one pixel with the object in slot 4
    function automatic pixel_out_t model_pixel(input win_cfg_t c, input pixel_in_t p);
        logic [5:0] m;
        layer_t     l [5];
        logic       vis [5];
        int         key [5];
        int         pick [2];
        layer_id_e  id [2];
        logic [7:0] idx [2];
        pixel_out_t r;
        m = select_mask(c, p);
        for (int i = 0; i < 5; i++) begin
            if (i == 4)
                l[i] = p.obj;
            else
                l[i] = p.bg[i];
            vis[i] = l[i].enable && m[i] && l[i].index != 8'd0 && !(i == 4 && l[i].objwin);
            // on equal prio the object ranks first, then the lower background
            key[i] = l[i].prio * 8 + ((i == 4) ? 0 : i + 1);
        end
        for (int k = 0; k < 2; k++) begin
            pick[k] = -1;
            for (int i = 0; i < 5; i++) begin
                if (vis[i] && (k == 0 || i != pick[0]) &&
                    (pick[k] < 0 || key[i] < key[pick[k]]))
                    pick[k] = i;
            end
            id[k]  = (pick[k] < 0) ? backdrop : layer_id_e'(pick[k]);
            idx[k] = (pick[k] < 0) ? 8'd0 : l[pick[k]].index;
        end
        r.id0     = id[0];
        r.id1     = id[1];
        r.color0  = pal_model[{id[0] == obj, idx[0]}];
        r.color1  = pal_model[{id[1] == obj, idx[1]}];
        r.effects = m[5];
        return r;
    endfunction

    task automatic check_color(input string name, input logic [color_w-1:0] got,
                               input logic [color_w-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_id(input string name, input layer_id_e got, input layer_id_e exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // out_valid must repeat pix_valid three cycles later
    always @(negedge clk) begin
        pixel_out_t e;
        check_flag("out_valid", out_valid, valid_hist[pipe_lat-1]);
        valid_hist = {valid_hist[pipe_lat-2:0], pix_valid};
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("an output pixel arrived while none was expected");
                other_errs++;
            end else begin
                e = exp_q.pop_front();
                check_color("color0", out.color0, e.color0);
                check_color("color1", out.color1, e.color1);
                check_id("id0", out.id0, e.id0);
                check_id("id1", out.id1, e.id1);
                check_flag("effects", out.effects, e.effects);
            end
        end
    end

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            pix_valid <= 1'b0;
        end
    endtask

    task automatic send_pixel(input pixel_in_t p);
        @(posedge clk);
        pix_valid <= 1'b1;
        pix       <= p;
        exp_q.push_back(model_pixel(cur_cfg, p));
    endtask

    task automatic wait_drain();
        int n;
        idle_cycles(1);
        n = 0;
        while (exp_q.size() != 0 && n < drain_limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out waiting for %0d pixels to leave the pipeline", exp_q.size());
            other_errs++;
            finish_run();
        end
    endtask

    task automatic write_palette(input logic [pal_aw-1:0] a, input logic [color_w-1:0] c);
        @(posedge clk);
        pal_we       <= 1'b1;
        pal_addr     <= a;
        pal_data     <= c;
        pal_model[a] = c;
    endtask

    task automatic set_config(input win_cfg_t c);
        @(posedge clk);
        cfg     <= c;
        cur_cfg = c;
    endtask

    function automatic layer_t rand_layer();
        layer_t l;
        l.enable = rand_bits(3) != 0;
        l.prio   = 2'(rand_bits(2));
        l.index  = (rand_bits(2) == 0) ? 8'd0 : 8'(rand_bits(8));
        l.objwin = rand_bits(2) == 0;
        return l;
    endfunction

    function automatic pixel_in_t rand_pixel();
        pixel_in_t p;
        p.x = 8'(rand_bits(8));
        p.y = 8'(rand_bits(8));
        for (int b = 0; b < num_bg; b++)
            p.bg[b] = rand_layer();
        p.obj = rand_layer();
        return p;
    endfunction

    // edges are sorted so the window never comes out inverted
    function automatic win_rect_t rand_rect();
        logic [7:0] e [4];
        logic [7:0] t;
        for (int i = 0; i < 4; i++)
            e[i] = 8'(rand_bits(8));
        for (int i = 0; i < 4; i += 2) begin
            if (e[i] > e[i+1]) begin
                t      = e[i];
                e[i]   = e[i+1];
                e[i+1] = t;
            end
        end
        return '{left: e[0], right: e[1], top: e[2], bottom: e[3]};
    endfunction

    function automatic win_cfg_t rand_cfg(input logic w0, input logic w1, input logic wo);
        win_cfg_t c;
        c.win0_on   = w0;
        c.win1_on   = w1;
        c.objwin_on = wo;
        c.win0_rect = rand_rect();
        c.win1_rect = rand_rect();
        c.in0       = 6'(rand_bits(6));
        c.in1       = 6'(rand_bits(6));
        c.inobj     = 6'(rand_bits(6));
        c.out       = 6'(rand_bits(6));
        return c;
    endfunction

    // mix of back-to-back strobes and short gaps
    task automatic random_burst(input int count);
        for (int i = 0; i < count; i++) begin
            send_pixel(rand_pixel());
            if (rand_bits(1))
                idle_cycles(rand_bits(2));
        end
        wait_drain();
    endtask

    initial begin
        pixel_in_t p;
        win_cfg_t  c;
        rst_n      = 1'b0;
        pix_valid  = 1'b0;
        pix        = '0;
        cfg        = '0;
        cur_cfg    = '0;
        pal_we     = 1'b0;
        pal_addr   = '0;
        pal_data   = '0;
        valid_hist = '0;
        value_errs = 0;
        other_errs = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int a = 0; a < 2**pal_aw; a++)
            write_palette(pal_aw'(a), color_w'(rand_bits(color_w)));
        @(posedge clk);
        pal_we <= 1'b0;
        idle_cycles(4);

        // no windows and random priorities with plenty of ties
        random_burst(80);

        // transparent, single visible, object window only, disabled layer
        p = '0;
        send_pixel(p);
        p.bg[2] = '{enable: 1'b1, prio: 2'd3, index: 8'h5a, objwin: 1'b0};
        send_pixel(p);
        p.obj   = '{enable: 1'b1, prio: 2'd0, index: 8'h5a, objwin: 1'b1};
        send_pixel(p);
        p.bg[1] = '{enable: 1'b0, prio: 2'd0, index: 8'h33, objwin: 1'b0};
        send_pixel(p);
        // object and bg2 share index 5a and read from different halves
        p.obj.objwin = 1'b0;
        send_pixel(p);
        wait_drain();

        set_config(rand_cfg(1'b1, 1'b0, 1'b0));
        random_burst(40);
        set_config(rand_cfg(1'b0, 1'b1, 1'b0));
        random_burst(40);
        set_config(rand_cfg(1'b0, 1'b0, 1'b1));
        random_burst(40);
        // overlapping windows where win0 has to win in the shared area
        c = rand_cfg(1'b1, 1'b1, 1'b1);
        c.win0_rect = '{left: 8'd40, right: 8'd160, top: 8'd40, bottom: 8'd160};
        c.win1_rect = '{left: 8'd80, right: 8'd220, top: 8'd80, bottom: 8'd220};
        set_config(c);
        random_burst(60);

        // rewrite part of the palette between bursts
        set_config('0);
        for (int k = 0; k < 64; k++)
            write_palette(pal_aw'(rand_bits(pal_aw)), color_w'(rand_bits(color_w)));
        write_palette(9'h000, color_w'(rand_bits(color_w)));
        write_palette(9'h15a, color_w'(rand_bits(color_w)));
        write_palette(9'h05a, color_w'(rand_bits(color_w)));
        @(posedge clk);
        pal_we <= 1'b0;
        send_pixel(p);
        send_pixel('0);
        random_burst(60);
        finish_run();
    end

endmodule

/* src/color_fetch.sv */
module color_fetch (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         srt_valid,
    input  comp_pkg::sorted_t            srt,
    input  logic                         pal_we,
    input  logic [comp_pkg::pal_aw-1:0]  pal_addr,
    input  logic [comp_pkg::color_w-1:0] pal_data,
    output logic                         out_valid,
    output comp_pkg::pixel_out_t         out
);
    import comp_pkg::*;

    logic [pal_aw-1:0]  addr0;
    logic [pal_aw-1:0]  addr1;
    logic [color_w-1:0] rdata0;
    logic [color_w-1:0] rdata1;
    layer_id_e          id0_q;
    layer_id_e          id1_q;
    logic               effects_q;

    // objects use the upper half of the palette
    assign addr0 = {srt.first.id == obj, srt.first.index};
    assign addr1 = {srt.second.id == obj, srt.second.index};

    palette_ram pal_i (
        .clk    (clk),
        .we     (pal_we),
        .waddr  (pal_addr),
        .wdata  (pal_data),
        .raddr0 (addr0),
        .raddr1 (addr1),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

    // metadata takes the same cycle as the ram read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            id0_q     <= bg0;
            id1_q     <= bg0;
            effects_q <= 1'b0;
        end else begin
            out_valid <= srt_valid;
            if (srt_valid) begin
                id0_q     <= srt.first.id;
                id1_q     <= srt.second.id;
                effects_q <= srt.effects;
            end
        end
    end

    assign out = '{color0: rdata0, color1: rdata1, id0: id0_q, id1: id1_q,
                   effects: effects_q};

    out_valid_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

/* src/comp_pkg.sv */
package comp_pkg;

    localparam int num_bg   = 4;
    localparam int coord_w  = 8;
    localparam int pal_aw   = 9;
    localparam int color_w  = 15;
    localparam int pipe_lat = 3;

    // layer identifiers, backdrop fills empty places
    typedef enum logic [2:0] {
        bg0      = 3'd0,
        bg1      = 3'd1,
        bg2      = 3'd2,
        bg3      = 3'd3,
        obj      = 3'd4,
        backdrop = 3'd5
    } layer_id_e;

    // one candidate, lower prio is in front, index 0 is transparent
    typedef struct packed {
        logic       enable;
        logic [1:0] prio;
        logic [7:0] index;
        logic       objwin;
    } layer_t;

    typedef struct packed {
        logic [coord_w-1:0]       x;
        logic [coord_w-1:0]       y;
        layer_t [num_bg-1:0]      bg;
        layer_t                   obj;
    } pixel_in_t;

    // inside when left <= x < right and top <= y < bottom
    typedef struct packed {
        logic [coord_w-1:0] left;
        logic [coord_w-1:0] right;
        logic [coord_w-1:0] top;
        logic [coord_w-1:0] bottom;
    } win_rect_t;

    // mask bits 3:0 backgrounds, bit 4 object, bit 5 effects
    typedef struct packed {
        logic       win0_on;
        logic       win1_on;
        logic       objwin_on;
        win_rect_t  win0_rect;
        win_rect_t  win1_rect;
        logic [5:0] in0;
        logic [5:0] in1;
        logic [5:0] inobj;
        logic [5:0] out;
    } win_cfg_t;

    typedef struct packed {
        pixel_in_t  pix;
        logic [4:0] mask;
        logic       effects;
    } decoded_t;

    typedef struct packed {
        layer_id_e  id;
        logic [7:0] index;
    } sort_entry_t;

    typedef struct packed {
        sort_entry_t first;
        sort_entry_t second;
        logic        effects;
    } sorted_t;

    typedef struct packed {
        logic [color_w-1:0] color0;
        logic [color_w-1:0] color1;
        layer_id_e          id0;
        layer_id_e          id1;
        logic               effects;
    } pixel_out_t;

endpackage

/* src/layer_sort.sv */
module layer_sort (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dec_valid,
    input  comp_pkg::decoded_t dec,
    output logic               srt_valid,
    output comp_pkg::sorted_t  srt
);
    import comp_pkg::*;

    localparam int num_cand = num_bg + 1;

    // slot 0 is the object so it wins prio ties, then bg0 to bg3
    layer_t      cand     [num_cand];
    layer_id_e   cand_id  [num_cand];
    logic        cand_vis [num_cand];
    sort_entry_t top0;
    sort_entry_t top1;

    always_comb begin
        cand[0]     = dec.pix.obj;
        cand_id[0]  = obj;
        cand_vis[0] = dec.pix.obj.enable && dec.mask[num_bg] &&
                      (dec.pix.obj.index != 8'd0) && !dec.pix.obj.objwin;
        for (int b = 0; b < num_bg; b++) begin
            cand[b+1]     = dec.pix.bg[b];
            cand_id[b+1]  = layer_id_e'(b);
            cand_vis[b+1] = dec.pix.bg[b].enable && dec.mask[b] &&
                            (dec.pix.bg[b].index != 8'd0);
        end
    end

    // walk prio levels front to back, slot order breaks ties
    always_comb begin
        int unsigned found;
        found = 0;
        top0  = '{id: backdrop, index: 8'd0};
        top1  = '{id: backdrop, index: 8'd0};
        for (int p = 0; p < 4; p++) begin
            for (int s = 0; s < num_cand; s++) begin
                if (cand_vis[s] && cand[s].prio == 2'(p)) begin
                    if (found == 0) begin
                        top0 = '{id: cand_id[s], index: cand[s].index};
                    end else if (found == 1) begin
                        top1 = '{id: cand_id[s], index: cand[s].index};
                    end
                    found++;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            srt_valid <= 1'b0;
            srt       <= '0;
        end else begin
            srt_valid <= dec_valid;
            if (dec_valid) begin
                srt <= '{first: top0, second: top1, effects: dec.effects};
            end
        end
    end

    // a layer can take only one place in the result
    distinct_ids_a: assert property (@(posedge clk) disable iff (!rst_n)
        srt_valid && srt.first.id != backdrop |-> srt.second.id != srt.first.id);

endmodule

/* src/palette_ram.sv */
module palette_ram (
    input  logic                        clk,
    input  logic                        we,
    input  logic [comp_pkg::pal_aw-1:0]  waddr,
    input  logic [comp_pkg::color_w-1:0] wdata,
    input  logic [comp_pkg::pal_aw-1:0]  raddr0,
    input  logic [comp_pkg::pal_aw-1:0]  raddr1,
    output logic [comp_pkg::color_w-1:0] rdata0,
    output logic [comp_pkg::color_w-1:0] rdata1
);
    import comp_pkg::*;

    localparam int depth = 2 ** pal_aw;

    logic [color_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both ports see the old word on a same-cycle write
    always_ff @(posedge clk) begin
        rdata0 <= mem[raddr0];
        rdata1 <= mem[raddr1];
    end

endmodule

/* src/pixel_compositor.sv */
module pixel_compositor (
    input  logic                         clk,
    input  logic                         rst_n,
    input  comp_pkg::win_cfg_t           cfg,
    input  logic                         pix_valid,
    input  comp_pkg::pixel_in_t          pix,
    input  logic                         pal_we,
    input  logic [comp_pkg::pal_aw-1:0]  pal_addr,
    input  logic [comp_pkg::color_w-1:0] pal_data,
    output logic                         out_valid,
    output comp_pkg::pixel_out_t         out
);
    import comp_pkg::*;

    logic     dec_valid;
    decoded_t dec;
    logic     srt_valid;
    sorted_t  srt;

    window_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .pix_valid (pix_valid),
        .pix       (pix),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    layer_sort sort_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .srt_valid (srt_valid),
        .srt       (srt)
    );

    color_fetch fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .srt_valid (srt_valid),
        .srt       (srt),
        .pal_we    (pal_we),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

/* src/window_decode.sv */
module window_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  comp_pkg::win_cfg_t  cfg,
    input  logic                pix_valid,
    input  comp_pkg::pixel_in_t pix,
    output logic                dec_valid,
    output comp_pkg::decoded_t  dec
);
    import comp_pkg::*;

    logic       in_win0;
    logic       in_win1;
    logic       in_objwin;
    logic       any_win_on;
    logic [5:0] sel_mask;

    function automatic logic inside_rect(
        input win_rect_t          r,
        input logic [coord_w-1:0] px,
        input logic [coord_w-1:0] py
    );
        return (px >= r.left) && (px < r.right) && (py >= r.top) && (py < r.bottom);
    endfunction

    assign in_win0    = cfg.win0_on && inside_rect(cfg.win0_rect, pix.x, pix.y);
    assign in_win1    = cfg.win1_on && inside_rect(cfg.win1_rect, pix.x, pix.y);
    assign in_objwin  = cfg.objwin_on && pix.obj.objwin;
    assign any_win_on = cfg.win0_on || cfg.win1_on || cfg.objwin_on;

    // win0 over win1 over object window, outside mask otherwise
    always_comb begin
        if (!any_win_on) begin
            sel_mask = '1;
        end else if (in_win0) begin
            sel_mask = cfg.in0;
        end else if (in_win1) begin
            sel_mask = cfg.in1;
        end else if (in_objwin) begin
            sel_mask = cfg.inobj;
        end else begin
            sel_mask = cfg.out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= pix_valid;
            if (pix_valid) begin
                dec <= '{pix: pix, mask: sel_mask[4:0], effects: sel_mask[5]};
            end
        end
    end

    // an inverted rectangle never contains a pixel, so its mask is dead
    rect_order_a: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |-> (!cfg.win0_on || cfg.win0_rect.left <= cfg.win0_rect.right) &&
                      (!cfg.win1_on || cfg.win1_rect.left <= cfg.win1_rect.right))
        else $warning("window rectangle with left edge beyond right edge");

endmodule
